// File: flist.f
lsu_pkg.sv
lsu_issue.sv
lsu_bus_fsm.sv
lsu_result_stage.sv
lsu_top.sv
tb_lsu_properties.sv
tb_lsu.sv

// File: lsu_bus_fsm.sv
module lsu_bus_fsm import lsu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            rd_start,
    input  logic            wr_start,
    input  logic            ex_ready,
    output logic            ar_valid,
    output logic            aw_valid,
    output logic            w_valid,
    input  logic            ar_ready,
    input  logic            aw_ready,
    input  logic            w_ready,
    input  logic            r_valid,
    input  logic            b_valid,
    input  logic [1:0]      r_resp,
    input  logic [1:0]      b_resp,
    input  logic [xlen-1:0] r_data,
    output logic            done,
    output bus_status_t     status
);

    typedef enum logic [1:0] {
        rd_idle,
        rd_wait_ar,
        rd_wait_r,
        rd_wait_out
    } rd_state_e;

    typedef enum logic [2:0] {
        wr_idle,
        wr_wait_aw_w,
        wr_wait_aw,
        wr_wait_w,
        wr_wait_b,
        wr_wait_out
    } wr_state_e;

    rd_state_e       rd_state;
    wr_state_e       wr_state;
    logic [xlen-1:0] rdata_q;
    logic            page_err_q;
    logic            access_err_q;
    logic            resp_fire;
    logic [1:0]      resp_code;

    // **************************************************
    // read side
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= rd_idle;
        end else begin
            unique case (rd_state)
                rd_idle: begin
                    if (rd_start) begin
                        rd_state <= rd_wait_ar;
                    end
                end
                rd_wait_ar: begin
                    if (ar_ready) begin
                        rd_state <= rd_wait_r;
                    end
                end
                rd_wait_r: begin
                    if (r_valid) begin
                        rd_state <= rd_wait_out;
                    end
                end
                rd_wait_out: begin
                    if (ex_ready) begin
                        rd_state <= rd_idle;
                    end
                end
                default: begin
                    rd_state <= rd_idle;
                end
            endcase
        end
    end

    // **************************************************
    // write side
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= wr_idle;
        end else begin
            unique case (wr_state)
                wr_idle: begin
                    if (wr_start) begin
                        wr_state <= wr_wait_aw_w;
                    end
                end
                wr_wait_aw_w: begin
                    // aw and w may finish in either order
                    if (aw_ready && w_ready) begin
                        wr_state <= wr_wait_b;
                    end else if (aw_ready) begin
                        wr_state <= wr_wait_w;
                    end else if (w_ready) begin
                        wr_state <= wr_wait_aw;
                    end
                end
                wr_wait_aw: begin
                    if (aw_ready) begin
                        wr_state <= wr_wait_b;
                    end
                end
                wr_wait_w: begin
                    if (w_ready) begin
                        wr_state <= wr_wait_b;
                    end
                end
                wr_wait_b: begin
                    if (b_valid) begin
                        wr_state <= wr_wait_out;
                    end
                end
                wr_wait_out: begin
                    if (ex_ready) begin
                        wr_state <= wr_idle;
                    end
                end
                default: begin
                    wr_state <= wr_idle;
                end
            endcase
        end
    end

    assign ar_valid = (rd_state == rd_wait_ar);
    assign aw_valid = (wr_state == wr_wait_aw_w) || (wr_state == wr_wait_aw);
    assign w_valid  = (wr_state == wr_wait_aw_w) || (wr_state == wr_wait_w);
    assign done     = (rd_state == rd_wait_out) || (wr_state == wr_wait_out);

    // **************************************************
    // response capture
    // **************************************************
    assign resp_fire = ((rd_state == rd_wait_r) && r_valid) ||
                       ((wr_state == wr_wait_b) && b_valid);
    assign resp_code = (rd_state == rd_wait_r) ? r_resp : b_resp;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            page_err_q   <= 1'b0;
            access_err_q <= 1'b0;
        end else if (resp_fire) begin
            page_err_q   <= (resp_code == resp_page_err);
            access_err_q <= (resp_code == resp_access_err);
        end else if (done && ex_ready) begin
            page_err_q   <= 1'b0;
            access_err_q <= 1'b0;
        end
    end

    // raw read beat before lane alignment
    always_ff @(posedge clk) begin
        if ((rd_state == rd_wait_r) && r_valid) begin
            rdata_q <= r_data;
        end
    end

    assign status = '{rdata: rdata_q, page_err: page_err_q, access_err: access_err_q};

endmodule

// File: lsu_issue.sv
module lsu_issue import lsu_pkg::*; (
    input  logic       ex_valid,
    input  ex_req_t    ex_req,
    output logic       rd_start,
    output logic       wr_start,
    output logic       misaligned,
    output bus_addr_t  ar_payload,
    output bus_addr_t  aw_payload,
    output bus_wdata_t w_payload
);

    logic              offset_bad;
    logic [strb_w-1:0] size_mask;
    logic [2:0]        lane;
    logic              is_load;
    logic              is_store;

    assign lane     = ex_req.addr[2:0];
    assign is_load  = (ex_req.kind == ls_load);
    assign is_store = (ex_req.kind == ls_store);

    // **************************************************
    // alignment check
    // **************************************************
    always_comb begin
        unique case (ex_req.size)
            size_byte: begin
                offset_bad = 1'b0;
            end
            size_half: begin
                offset_bad = ex_req.addr[0];
            end
            size_word: begin
                offset_bad = |ex_req.addr[1:0];
            end
            default: begin
                offset_bad = |ex_req.addr[2:0];
            end
        endcase
    end

    // only a real load or store can trap here
    assign misaligned = ex_valid && (ex_req.kind != ls_none) && offset_bad;

    // bus work only for aligned requests
    assign rd_start = ex_valid && is_load && !offset_bad;
    assign wr_start = ex_valid && is_store && !offset_bad;

    // **************************************************
    // bus payloads
    // **************************************************
    always_comb begin
        unique case (ex_req.size)
            size_byte: begin
                size_mask = 8'h01;
            end
            size_half: begin
                size_mask = 8'h03;
            end
            size_word: begin
                size_mask = 8'h0f;
            end
            default: begin
                size_mask = 8'hff;
            end
        endcase
    end

    // same address phase for both channels
    assign ar_payload = '{addr: ex_req.addr, size: ex_req.size};
    assign aw_payload = '{addr: ex_req.addr, size: ex_req.size};

    // store data moved up into its byte lanes
    always_comb begin
        w_payload.strb = size_mask << lane;
        w_payload.data = ex_req.store_data << {lane, 3'b000};
    end

endmodule

// File: lsu_pkg.sv
package lsu_pkg;

    // **************************************************
    // widths
    // **************************************************
    localparam int xlen       = 64;
    localparam int strb_w     = 8;
    localparam int reg_addr_w = 5;

    // access size as driven on ar and aw
    typedef enum logic [1:0] {
        size_byte   = 2'd0,
        size_half   = 2'd1,
        size_word   = 2'd2,
        size_double = 2'd3
    } mem_size_e;

    typedef enum logic [1:0] {
        ls_none  = 2'd0,
        ls_load  = 2'd1,
        ls_store = 2'd2
    } ls_kind_e;

    // any other bus response code is success
    localparam logic [1:0] resp_ok         = 2'd0;
    localparam logic [1:0] resp_page_err   = 2'd2;
    localparam logic [1:0] resp_access_err = 2'd3;

    // **************************************************
    // trap causes
    // **************************************************
    localparam logic [xlen-1:0] cause_load_misaligned  = xlen'(4);
    localparam logic [xlen-1:0] cause_load_access      = xlen'(5);
    localparam logic [xlen-1:0] cause_store_misaligned = xlen'(6);
    localparam logic [xlen-1:0] cause_store_access     = xlen'(7);
    localparam logic [xlen-1:0] cause_load_page        = xlen'(13);
    localparam logic [xlen-1:0] cause_store_page       = xlen'(15);

    // **************************************************
    // payloads
    // **************************************************
    typedef struct packed {
        ls_kind_e               kind;
        mem_size_e              size;
        logic                   is_signed;
        logic [xlen-1:0]        addr;
        logic [xlen-1:0]        store_data;
        logic [reg_addr_w-1:0]  rd;
    } ex_req_t;

    // shared by ar and aw
    typedef struct packed {
        logic [xlen-1:0] addr;
        mem_size_e       size;
    } bus_addr_t;

    typedef struct packed {
        logic [xlen-1:0]   data;
        logic [strb_w-1:0] strb;
    } bus_wdata_t;

    typedef struct packed {
        logic [xlen-1:0] rdata;
        logic            page_err;
        logic            access_err;
    } bus_status_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] rd;
        logic                  dest_wen;
        logic [xlen-1:0]       data;
        logic                  trap;
        logic [xlen-1:0]       cause;
        logic [xlen-1:0]       tval;
    } wb_result_t;

endpackage

// File: lsu_result_stage.sv
module lsu_result_stage import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ex_valid,
    input  ex_req_t     ex_req,
    input  logic        misaligned,
    input  logic        done,
    input  bus_status_t status,
    output logic        ex_ready,
    output logic        wb_valid,
    input  logic        wb_ready,
    output wb_result_t  wb
);

    logic [xlen-1:0] shifted;
    logic [xlen-1:0] load_data;
    logic            is_load;
    logic            trap;
    logic [xlen-1:0] cause;
    logic            reg_free;
    logic            wb_valid_q;
    wb_result_t      wb_next;
    wb_result_t      wb_q;

    assign is_load = (ex_req.kind == ls_load);

    // **************************************************
    // load alignment
    // **************************************************
    assign shifted = status.rdata >> {ex_req.addr[2:0], 3'b000};

    always_comb begin
        unique case (ex_req.size)
            size_byte: begin
                load_data = ex_req.is_signed ? {{(xlen-8){shifted[7]}}, shifted[7:0]}
                                             : {{(xlen-8){1'b0}}, shifted[7:0]};
            end
            size_half: begin
                load_data = ex_req.is_signed ? {{(xlen-16){shifted[15]}}, shifted[15:0]}
                                             : {{(xlen-16){1'b0}}, shifted[15:0]};
            end
            size_word: begin
                load_data = ex_req.is_signed ? {{(xlen-32){shifted[31]}}, shifted[31:0]}
                                             : {{(xlen-32){1'b0}}, shifted[31:0]};
            end
            default: begin
                load_data = shifted;
            end
        endcase
    end

    // **************************************************
    // trap select
    // **************************************************
    assign trap = misaligned || status.page_err || status.access_err;

    // misaligned first, then page, then access
    always_comb begin
        if (misaligned) begin
            cause = is_load ? cause_load_misaligned : cause_store_misaligned;
        end else if (status.page_err) begin
            cause = is_load ? cause_load_page : cause_store_page;
        end else if (status.access_err) begin
            cause = is_load ? cause_load_access : cause_store_access;
        end else begin
            cause = '0;
        end
    end

    always_comb begin
        wb_next.rd       = ex_req.rd;
        wb_next.dest_wen = is_load && !trap;
        wb_next.data     = (is_load && !trap) ? load_data : '0;
        wb_next.trap     = trap;
        wb_next.cause    = cause;
        wb_next.tval     = trap ? ex_req.addr : '0;
    end

    // **************************************************
    // writeback register
    // **************************************************
    assign reg_free = !wb_valid_q || wb_ready;
    assign ex_ready = ex_valid && reg_free && (done || misaligned);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid_q <= 1'b0;
        end else if (reg_free) begin
            wb_valid_q <= ex_ready;
        end
    end

    // held while writeback stalls
    always_ff @(posedge clk) begin
        if (ex_ready) begin
            wb_q <= wb_next;
        end
    end

    assign wb_valid = wb_valid_q;
    assign wb       = wb_q;

endmodule

// File: lsu_top.sv
module lsu_top import lsu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    // execute
    input  logic            ex_valid,
    input  ex_req_t         ex_req,
    output logic            ex_ready,
    // read channels
    output logic            ar_valid,
    input  logic            ar_ready,
    output bus_addr_t       ar,
    input  logic            r_valid,
    input  logic [1:0]      r_resp,
    input  logic [xlen-1:0] r_data,
    // write channels
    output logic            aw_valid,
    input  logic            aw_ready,
    output bus_addr_t       aw,
    output logic            w_valid,
    input  logic            w_ready,
    output bus_wdata_t      w,
    input  logic            b_valid,
    input  logic [1:0]      b_resp,
    // writeback
    output logic            wb_valid,
    input  logic            wb_ready,
    output wb_result_t      wb
);

    logic        rd_start;
    logic        wr_start;
    logic        misaligned;
    logic        done;
    bus_status_t status;

    lsu_issue u_issue (
        .ex_valid   (ex_valid),
        .ex_req     (ex_req),
        .rd_start   (rd_start),
        .wr_start   (wr_start),
        .misaligned (misaligned),
        .ar_payload (ar),
        .aw_payload (aw),
        .w_payload  (w)
    );

    lsu_bus_fsm u_bus (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_start (rd_start),
        .wr_start (wr_start),
        .ex_ready (ex_ready),
        .ar_valid (ar_valid),
        .aw_valid (aw_valid),
        .w_valid  (w_valid),
        .ar_ready (ar_ready),
        .aw_ready (aw_ready),
        .w_ready  (w_ready),
        .r_valid  (r_valid),
        .b_valid  (b_valid),
        .r_resp   (r_resp),
        .b_resp   (b_resp),
        .r_data   (r_data),
        .done     (done),
        .status   (status)
    );

    lsu_result_stage u_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_valid   (ex_valid),
        .ex_req     (ex_req),
        .misaligned (misaligned),
        .done       (done),
        .status     (status),
        .ex_ready   (ex_ready),
        .wb_valid   (wb_valid),
        .wb_ready   (wb_ready),
        .wb         (wb)
    );

endmodule

// File: run.sh
#!/bin/sh
# build and run the LSU regression with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f flist.f --top-module tb_lsu -o tb_lsu || exit 1

out="$(./obj_dir/tb_lsu 2>&1)"
echo "$out"

echo "$out" | grep -q "^Regression passed$" && exit 0 || exit 1

// File: tb_lsu.sv
module tb_lsu import lsu_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period   = 4;
    localparam int num_requests = 32 + 32 + 12 + 8 + 200;
    localparam int max_cycles   = 24;
    localparam int margin       = 4;
    localparam int watchdog_ns  = num_requests * max_cycles * margin * clk_period;

    logic            clk;
    logic            rst_n;
    logic            ex_valid;
    ex_req_t         ex_req;
    logic            ex_ready;
    logic            ar_valid;
    logic            ar_ready;
    bus_addr_t       ar;
    logic            r_valid;
    logic [1:0]      r_resp;
    logic [xlen-1:0] r_data;
    logic            aw_valid;
    logic            aw_ready;
    bus_addr_t       aw;
    logic            w_valid;
    logic            w_ready;
    bus_wdata_t      w;
    logic            b_valid;
    logic [1:0]      b_resp;
    logic            wb_valid;
    logic            wb_ready;
    wb_result_t      wb;

    logic [31:0]     lfsr;
    logic [7:0]      mem [256];
    logic [7:0]      ref_mem [256];
    wb_result_t      expected_q [$];
    wb_result_t      exp_result;
    logic [1:0]      cur_resp;
    string           test_name = "reset";
    int              checks = 0;
    int              errors = 0;
    int              test_checks = 0;
    int              test_errors = 0;
    logic            expect_no_bus = 1'b0;
    int              low_cycles [4] = '{0, 0, 0, 0};
    // responder state
    logic            ar_fire = 1'b0;
    logic            aw_fire = 1'b0;
    logic            w_fire = 1'b0;
    logic            r_pending = 1'b0;
    logic            b_pending = 1'b0;
    logic            aw_seen = 1'b0;
    logic            w_seen = 1'b0;
    int              r_delay = 0;
    int              b_delay = 0;
    logic [7:0]      rd_addr = 8'h0;
    logic [7:0]      wr_addr = 8'h0;
    logic [63:0]     wr_data = 64'h0;
    logic [7:0]      wr_strb = 8'h0;

    lsu_top u_dut (.*);

    always #(clk_period / 2) clk = ~clk;

    // **************************************************
    // random source
    // **************************************************
    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_bit()};
        end
        return v;
    endfunction

    // never low for more than 3 cycles in a row
    function automatic logic pick_ready(input logic [1:0] idx, input logic mostly_high);
        logic r;
        r = lfsr_bit();
        if (mostly_high) begin
            r = r | lfsr_bit();
        end
        if (low_cycles[idx] >= 3) begin
            r = 1'b1;
        end
        low_cycles[idx] = r ? 0 : low_cycles[idx] + 1;
        return r;
    endfunction

    function automatic logic [1:0] pick_resp();
        logic [2:0] roll;
        roll = 3'(rand_bits(3));
        return (roll == 3'd6) ? resp_page_err : (roll == 3'd7) ? resp_access_err : resp_ok;
    endfunction

    function automatic logic [7:0] aligned_addr(input mem_size_e size);
        return 8'(rand_bits(8)) & ~8'((1 << int'(size)) - 1);
    endfunction

    // size must be wider than a byte
    function automatic logic [7:0] misaligned_addr(input mem_size_e size);
        int span;
        span = 1 << int'(size);
        return aligned_addr(size) | 8'(1 + int'(rand_bits(3)) % (span - 1));
    endfunction

    function automatic ex_req_t make_req(input ls_kind_e kind, input mem_size_e size,
                                         input logic is_signed, input logic [7:0] addr);
        ex_req_t req;
        req.kind       = kind;
        req.size       = size;
        req.is_signed  = is_signed;
        req.addr       = 64'(addr);
        req.store_data = rand_bits(64);
        req.rd         = 5'(rand_bits(5));
        return req;
    endfunction

    // **************************************************
    // reference model
    // **************************************************
    function automatic wb_result_t expected_result(input ex_req_t req, input logic [7:0] img [256],
                                                   input logic [1:0] resp);
        wb_result_t res;
        int         nbytes;
        logic       is_load;
        logic       sign;
        logic [63:0] raw;
        nbytes  = 1 << int'(req.size);
        is_load = (req.kind == ls_load);
        raw     = '0;
        res     = '0;
        res.rd  = req.rd;
        if (|(req.addr[2:0] & 3'(nbytes - 1))) begin
            res.trap  = 1'b1;
            res.cause = is_load ? cause_load_misaligned : cause_store_misaligned;
        end else if (resp == resp_page_err) begin
            res.trap  = 1'b1;
            res.cause = is_load ? cause_load_page : cause_store_page;
        end else if (resp == resp_access_err) begin
            res.trap  = 1'b1;
            res.cause = is_load ? cause_load_access : cause_store_access;
        end
        if (res.trap) begin
            res.tval = req.addr;
        end else if (is_load) begin
            for (int i = 0; i < nbytes; i++) begin
                raw = raw | (64'(img[req.addr[7:0] + 8'(i)]) << (8 * i));
            end
            sign = 1'(raw >> (8 * nbytes - 1));
            if (req.is_signed && sign) begin
                raw = raw | (~64'h0 << (8 * nbytes));
            end
            res.data     = raw;
            res.dest_wen = 1'b1;
        end
        return res;
    endfunction

    function automatic void store_ref(input ex_req_t req);
        for (int i = 0; i < (1 << int'(req.size)); i++) begin
            ref_mem[req.addr[7:0] + 8'(i)] = 8'(req.store_data >> (8 * i));
        end
    endfunction

    function automatic logic [63:0] read_double(input logic [7:0] a);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < 8; k++) begin
            v = v | (64'(mem[{a[7:3], 3'(k)}]) << (8 * k));
        end
        return v;
    endfunction

    // address phase must carry the request's own address and size
    task automatic check_addr_phase(input string chan, input bus_addr_t got);
        if (got.addr !== ex_req.addr || got.size !== ex_req.size) begin
            $display("FAILED %s: %s expected %h size %0d actual %h size %0d", test_name, chan,
                     ex_req.addr, ex_req.size, got.addr, got.size);
            errors++;
            test_errors++;
        end
    endtask

    // **************************************************
    // memory responder, readies and writeback stalls
    // **************************************************
    always begin
        @(negedge clk);
        r_valid = 1'b0;
        b_valid = 1'b0;
        if (ar_fire) begin
            r_pending = 1'b1;
            r_delay   = int'(rand_bits(2));
        end
        if (r_pending) begin
            if (r_delay == 0) begin
                r_valid   = 1'b1;
                r_resp    = cur_resp;
                r_data    = read_double(rd_addr);
                r_pending = 1'b0;
            end else begin
                r_delay--;
            end
        end
        aw_seen = aw_seen || aw_fire;
        w_seen  = w_seen || w_fire;
        if (aw_seen && w_seen) begin
            // a faulting write leaves memory alone
            if (cur_resp != resp_page_err && cur_resp != resp_access_err) begin
                for (int k = 0; k < 8; k++) begin
                    if (1'(wr_strb >> k)) begin
                        mem[{wr_addr[7:3], 3'(k)}] = 8'(wr_data >> (8 * k));
                    end
                end
            end
            aw_seen   = 1'b0;
            w_seen    = 1'b0;
            b_pending = 1'b1;
            b_delay   = int'(rand_bits(2));
        end
        if (b_pending) begin
            if (b_delay == 0) begin
                b_valid   = 1'b1;
                b_resp    = cur_resp;
                b_pending = 1'b0;
            end else begin
                b_delay--;
            end
        end
        ar_ready = pick_ready(2'd0, 1'b0);
        aw_ready = pick_ready(2'd1, 1'b0);
        w_ready  = pick_ready(2'd2, 1'b0);
        wb_ready = pick_ready(2'd3, 1'b1);
        // handshakes seen here complete at the next rising edge
        #1;
        ar_fire = ar_valid && ar_ready;
        aw_fire = aw_valid && aw_ready;
        w_fire  = w_valid && w_ready;
        if (ar_fire) begin
            rd_addr = ar.addr[7:0];
            check_addr_phase("ar", ar);
        end
        if (aw_fire) begin
            wr_addr = aw.addr[7:0];
            check_addr_phase("aw", aw);
        end
        if (w_fire) begin
            wr_data = w.data;
            wr_strb = w.strb;
        end
    end

    // **************************************************
    // result checker
    // **************************************************
    always begin
        @(negedge clk);
        #1;
        if (rst_n && expect_no_bus && (ar_valid || aw_valid || w_valid)) begin
            $display("ERROR %s: a bus valid went high for a misaligned request", test_name);
            errors++;
            test_errors++;
        end
        if (rst_n && wb_valid && wb_ready) begin
            if (expected_q.size() == 0) begin
                $display("ERROR %s: writeback result with no request outstanding", test_name);
                errors++;
                test_errors++;
            end else begin
                exp_result = expected_q.pop_front();
                checks++;
                test_checks++;
                if (wb !== exp_result) begin
                    $display("FAILED %s: expected %h actual %h", test_name, exp_result, wb);
                    errors++;
                    test_errors++;
                end
            end
        end
    end

    // **************************************************
    // stimulus
    // **************************************************
    // entered and left at a falling edge
    task automatic send(input ex_req_t req, input logic [1:0] resp);
        wb_result_t want;
        want = expected_result(req, ref_mem, resp);
        expected_q.push_back(want);
        if (req.kind == ls_store && !want.trap) begin
            store_ref(req);
        end
        cur_resp = resp;
        ex_valid = 1'b1;
        ex_req   = req;
        #1;
        while (!ex_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        ex_valid = 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        while (expected_q.size() != 0) begin
            @(negedge clk);
        end
        $display("%s: %0d results checked, %0d errors", test_name, test_checks, test_errors);
    endtask

    task automatic aligned_loads();
        begin_test("aligned_loads");
        for (int s = 0; s < 4; s++) begin
            for (int sg = 0; sg < 2; sg++) begin
                for (int n = 0; n < 4; n++) begin
                    send(make_req(ls_load, mem_size_e'(s), 1'(sg),
                                  aligned_addr(mem_size_e'(s))), resp_ok);
                end
            end
        end
        end_test();
    endtask

    task automatic store_merge();
        ex_req_t st;
        begin_test("store_merge");
        for (int s = 0; s < 4; s++) begin
            for (int n = 0; n < 4; n++) begin
                st = make_req(ls_store, mem_size_e'(s), 1'b0, aligned_addr(mem_size_e'(s)));
                send(st, resp_ok);
                // read back the whole double word
                send(make_req(ls_load, size_double, 1'b0, {st.addr[7:3], 3'b000}), resp_ok);
            end
        end
        end_test();
    endtask

    task automatic misaligned_traps();
        mem_size_e sz;
        begin_test("misaligned_traps");
        expect_no_bus = 1'b1;
        for (int n = 0; n < 12; n++) begin
            sz = mem_size_e'(1 + n % 3);
            send(make_req((n % 2 == 1) ? ls_store : ls_load, sz, 1'(rand_bits(1)),
                          misaligned_addr(sz)), resp_ok);
        end
        end_test();
        expect_no_bus = 1'b0;
    endtask

    task automatic bus_faults();
        mem_size_e sz;
        begin_test("bus_faults");
        for (int n = 0; n < 8; n++) begin
            sz = mem_size_e'(rand_bits(2));
            send(make_req((n % 2 == 1) ? ls_store : ls_load, sz, 1'(rand_bits(1)),
                          aligned_addr(sz)), (n % 4 < 2) ? resp_page_err : resp_access_err);
        end
        end_test();
    endtask

    task automatic random_traffic();
        begin_test("random_traffic");
        for (int n = 0; n < 200; n++) begin
            send(make_req(rand_bits(1) != 0 ? ls_store : ls_load, mem_size_e'(rand_bits(2)),
                          1'(rand_bits(1)), 8'(rand_bits(8))), pick_resp());
        end
        end_test();
    endtask

    // **************************************************
    // main sequence and watchdog
    // **************************************************
    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        ex_valid = 1'b0;
        ex_req   = '0;
        ar_ready = 1'b0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        r_valid  = 1'b0;
        r_resp   = resp_ok;
        r_data   = '0;
        b_valid  = 1'b0;
        b_resp   = resp_ok;
        wb_ready = 1'b0;
        cur_resp = resp_ok;
        lfsr     = 32'ha038;
        for (int i = 0; i < 256; i++) begin
            mem[8'(i)]     = 8'((i * 37) ^ (i >> 5) ^ 'h5a);
            ref_mem[8'(i)] = mem[8'(i)];
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        if (ar_valid || aw_valid || w_valid || wb_valid || ex_ready) begin
            $display("ERROR reset: a valid or ex_ready is high after reset");
            errors++;
        end
        @(negedge clk);
        aligned_loads();
        store_merge();
        misaligned_traps();
        bus_faults();
        random_traffic();
        if (checks != num_requests) begin
            $display("ERROR: %0d requests sent but %0d results seen", num_requests, checks);
            errors++;
        end
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: tests still running after %0d ns, stuck in %s", watchdog_ns, test_name);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: tb_lsu_properties.sv
module tb_lsu_properties import lsu_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input ex_req_t    ex_req,
    input logic       ar_valid,
    input logic       ar_ready,
    input bus_addr_t  ar,
    input logic       aw_valid,
    input logic       aw_ready,
    input bus_addr_t  aw,
    input logic       w_valid,
    input logic       w_ready,
    input bus_wdata_t w,
    input logic       wb_valid,
    input logic       wb_ready,
    input wb_result_t wb
);
    timeunit 1ns;
    timeprecision 100ps;

    // **************************************************
    // bus channels hold until accepted
    // **************************************************
    ar_held: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else $error("ar_valid dropped or ar changed before ar_ready");

    aw_held: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else $error("aw_valid dropped or aw changed before aw_ready");

    w_held: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else $error("w_valid dropped or w changed before w_ready");

    // writeback under stall
    wb_held: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb))
        else $error("wb changed while writeback stalled");

    no_read_for_store: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid |-> ex_req.kind != ls_store)
        else $error("ar_valid high for a store request");

endmodule

bind lsu_top tb_lsu_properties u_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .ex_req   (ex_req),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .ar       (ar),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .aw       (aw),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .w        (w),
    .wb_valid (wb_valid),
    .wb_ready (wb_ready),
    .wb       (wb)
);
